// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_master
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/spi_bit_engine.sv
`timescale 1ns/10ps

module spi_bit_engine #(
   parameter int BAUD_WIDTH = 8
) (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       miso_i,
   output logic       sclk_o,
   output logic       mosi_o,
   spi_xfer_if.engine xfer
);

   import spi_pkg::*;

   seq_state_e            state_q;
   seq_state_e            state_d;
   logic [BAUD_WIDTH-1:0] cnt_q;       // half bit down counter.
   logic [BAUD_WIDTH-1:0] cnt_d;
   logic [2:0]            bit_q;       // bits left in the byte, minus one.
   logic [2:0]            bit_d;
   spi_byte_t             sr_q;
   logic                  lead_level;  // sclk during PHASE2.

   assign lead_level = xfer.cpol ^ xfer.cpha;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // phase sequencer.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      state_d    = state_q;
      cnt_d      = xfer.divisor;   // reload whenever the count is not running.
      bit_d      = bit_q;
      sclk_o     = xfer.cpol;
      xfer.load  = 1'b0;
      xfer.shift = 1'b0;

      case (state_q)
         SEQ_IDLE:
         begin
            if (xfer.buf_full)
            begin
               bit_d     = 3'd7;
               xfer.load = 1'b1;
               state_d   = SEQ_PHASE2;
            end
         end

         SEQ_PHASE2:
         begin
            sclk_o = lead_level;
            if (cnt_q == '0)
               state_d = SEQ_PHASE1;
            else
               cnt_d = cnt_q - 1'b1;
         end

         SEQ_PHASE1:
         begin
            sclk_o = ~lead_level;
            if (cnt_q == '0)
            begin
               xfer.shift = 1'b1;     // sample point.
               bit_d      = bit_q - 1'b1;
               if (bit_q != 3'd0)
                  state_d = SEQ_PHASE2;
               else if (xfer.buf_full)
               begin
                  // next byte follows without a gap.
                  bit_d     = 3'd7;
                  xfer.load = 1'b1;
                  state_d   = SEQ_PHASE2;
               end
               else
                  state_d = SEQ_IDLE;
            end
            else
               cnt_d = cnt_q - 1'b1;
         end

         default:
            state_d = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         state_q <= SEQ_IDLE;
      else
         state_q <= state_d;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // counters and shift register.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_i)
   begin
      cnt_q <= cnt_d;
      bit_q <= bit_d;
      if (xfer.load)
         sr_q <= xfer.tx_byte;
      else if (xfer.shift)
         sr_q <= xfer.shift_next;   // msb out, miso in at the bottom.
   end

   assign xfer.shift_next = {sr_q[6:0], miso_i};
   assign xfer.shift_q    = sr_q;
   assign xfer.state      = state_q;

   assign mosi_o = sr_q[7];

endmodule

// File: hw/spi_host_regs.sv
`timescale 1ns/10ps

module spi_host_regs #(
   parameter int BAUD_WIDTH = 8,
   parameter int SPI_MODE   = 4
) (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               stb_i,
   input  logic               we_i,
   input  spi_pkg::reg_addr_t adr_i,
   input  spi_pkg::bus_word_t dat_i,
   output spi_pkg::bus_word_t dat_o,
   output logic               int_o,
   spi_xfer_if.regs           xfer
);

   import spi_pkg::*;

   // a value of 0 to 3 ties the mode, anything else uses the register.
   localparam bit         MODE_FIXED = (SPI_MODE >= 0) && (SPI_MODE < 4);
   localparam logic [1:0] MODE_BITS  = 2'(SPI_MODE);

   logic                  wr;
   logic                  txbuf_stb;
   logic                  irq_stb;
   logic                  mode_stb;
   logic                  baud_stb;

   spi_byte_t             buf_q;
   logic                  buf_full_q;
   logic                  txr_en_q;
   logic                  txe_en_q;
   logic                  cpol_q;
   logic                  cpha_q;
   logic [BAUD_WIDTH-1:0] div_q;

   logic                  tx_ready;
   logic                  tx_empty;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // write decode.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign wr        = stb_i & we_i;
   assign txbuf_stb = wr & (adr_i == ADDR_TXBUF);
   assign irq_stb   = wr & (adr_i == ADDR_IRQ);
   assign mode_stb  = wr & (adr_i == ADDR_MODE);
   assign baud_stb  = wr & (adr_i == ADDR_BAUD);

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         buf_full_q <= 1'b0;
         txr_en_q   <= 1'b0;
         txe_en_q   <= 1'b0;
         cpol_q     <= 1'b0;
         cpha_q     <= 1'b0;
         div_q      <= '0;
      end
      else
      begin
         if (irq_stb)
            {txr_en_q, txe_en_q} <= dat_i[1:0];
         if (mode_stb)
            {cpol_q, cpha_q} <= dat_i[1:0];
         if (baud_stb)
            div_q <= dat_i[BAUD_WIDTH-1:0];
         // a new write wins over a load in the same cycle.
         if (txbuf_stb)
            buf_full_q <= 1'b1;
         else if (xfer.load)
            buf_full_q <= 1'b0;
      end
   end

   // the buffer doubles as the receive holding register.
   // a load at the end of a byte must take the final sampled bit too.
   always_ff @(posedge clk_i)
   begin
      if (txbuf_stb)
         buf_q <= dat_i[7:0];
      else if (xfer.load)
         buf_q <= (xfer.state == SEQ_IDLE) ? xfer.shift_q : xfer.shift_next;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // to the bit engine.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign xfer.buf_full = buf_full_q;
   assign xfer.tx_byte  = buf_q;
   assign xfer.cpol     = MODE_FIXED ? MODE_BITS[1] : cpol_q;
   assign xfer.cpha     = MODE_FIXED ? MODE_BITS[0] : cpha_q;
   assign xfer.divisor  = div_q;

   // status and interrupt.
   assign tx_ready = ~buf_full_q;                 // room for another byte.
   assign tx_empty = (xfer.state == SEQ_IDLE);    // serial side quiet.

   assign int_o = (tx_ready & txr_en_q) | (tx_empty & txe_en_q);

   // read mux, purely combinational from the address.
   always_comb
   begin
      dat_o = '0;
      case (adr_i)
         ADDR_RXSHIFT: dat_o[7:0] = xfer.shift_q;
         ADDR_TXBUF:   dat_o[7:0] = buf_q;
         ADDR_IRQ:     dat_o[1:0] = {tx_ready, tx_empty};
         default:      dat_o      = '0;   // mode and baud are write only.
      endcase
   end

endmodule

// File: hw/spi_master_top.sv
`timescale 1ns/10ps

module spi_master_top #(
   parameter int BAUD_WIDTH = 8,   // divisor and half bit counter width.
   parameter int SPI_MODE   = 4    // 0..3 fixed mode, 4 programmable.
) (
   input  logic               clk_i,
   input  logic               rst_i,

   // host register port.
   input  logic               stb_i,
   input  logic               we_i,
   input  spi_pkg::reg_addr_t adr_i,
   input  spi_pkg::bus_word_t dat_i,
   output spi_pkg::bus_word_t dat_o,
   output logic               int_o,

   // serial pins.
   input  logic               miso_i,
   output logic               mosi_o,
   output logic               sclk_o
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // link between the register stage and the bit engine.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   spi_xfer_if #(
      .BAUD_WIDTH (BAUD_WIDTH)
   ) xfer ();

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stages.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // registers, buffer byte, status and interrupt.
   spi_host_regs #(
      .BAUD_WIDTH (BAUD_WIDTH),
      .SPI_MODE   (SPI_MODE)
   ) u_regs (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .stb_i (stb_i),
      .we_i  (we_i),
      .adr_i (adr_i),
      .dat_i (dat_i),
      .dat_o (dat_o),
      .int_o (int_o),
      .xfer  (xfer.regs)
   );

   // timing, sequencing and the shifter.
   spi_bit_engine #(
      .BAUD_WIDTH (BAUD_WIDTH)
   ) u_engine (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .miso_i (miso_i),
      .sclk_o (sclk_o),
      .mosi_o (mosi_o),
      .xfer   (xfer.engine)
   );

endmodule

// File: hw/spi_pkg.sv
package spi_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // vector types.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [7:0]  spi_byte_t;   // one serial byte.
   typedef logic [31:0] bus_word_t;   // host bus data.
   typedef logic [2:0]  reg_addr_t;   // host bus register address.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register map.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // read only, returns the live shift register.
   localparam reg_addr_t ADDR_RXSHIFT = 3'd0;

   // write queues a byte, read returns the buffer.
   localparam reg_addr_t ADDR_TXBUF   = 3'd1;

   // write sets the enables, read returns {tx_ready, tx_empty}.
   localparam reg_addr_t ADDR_IRQ     = 3'd2;

   // bit 1 cpol, bit 0 cpha.
   localparam reg_addr_t ADDR_MODE    = 3'd3;

   // half bit length minus one, in clk_i cycles.
   localparam reg_addr_t ADDR_BAUD    = 3'd4;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bit sequencer states.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [1:0] {
      SEQ_IDLE   = 2'd0,   // nothing shifting.
      SEQ_PHASE1 = 2'd1,   // second half of a bit, ends with the sample.
      SEQ_PHASE2 = 2'd2    // first half of a bit.
   } seq_state_e;

endpackage

// File: hw/spi_xfer_if.sv
`timescale 1ns/10ps

interface spi_xfer_if #(
   parameter int BAUD_WIDTH = 8
);

   import spi_pkg::*;

   // register stage to bit engine.
   logic                  buf_full;     // a byte is queued.
   spi_byte_t             tx_byte;      // the queued byte.
   logic                  cpol;
   logic                  cpha;
   logic [BAUD_WIDTH-1:0] divisor;

   // bit engine to register stage.
   logic                  load;         // buffer moves into the shifter.
   logic                  shift;        // one bit moves through the shifter.
   seq_state_e            state;
   spi_byte_t             shift_next;   // shifter value after the next shift.
   spi_byte_t             shift_q;

   modport regs (
      output buf_full, tx_byte, cpol, cpha, divisor,
      input  load, state, shift_next, shift_q
   );

   modport engine (
      input  buf_full, tx_byte, cpol, cpha, divisor,
      output load, shift, state, shift_next, shift_q
   );

endinterface

// File: sources.f
hw/spi_pkg.sv
hw/spi_xfer_if.sv
hw/spi_host_regs.sv
hw/spi_bit_engine.sv
hw/spi_master_top.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// File: verification/spi_slave_model.sv
`timescale 1ns/10ps

module spi_slave_model (
   input  logic              sclk_i,
   input  logic              mosi_i,
   input  logic              cpol_i,
   input  logic              cpha_i,
   output logic              miso_o,
   output spi_pkg::spi_byte_t last_rx_o
);

   import spi_pkg::*;

   spi_byte_t reply_q[$];      // bytes to send, in order.
   spi_byte_t captured_q[$];   // bytes seen on mosi, in order.
   spi_byte_t tx_sr;
   spi_byte_t rx_sr;
   int        bit_cnt;

   initial
   begin
      miso_o    = 1'b0;
      last_rx_o = '0;
      tx_sr     = '0;
      rx_sr     = '0;
      bit_cnt   = 0;
   end

   task automatic clear();
      reply_q.delete();
      captured_q.delete();
      bit_cnt = 0;
      rx_sr   = '0;
   endtask

   task automatic push_reply(input spi_byte_t b);
      reply_q.push_back(b);
   endtask

   // with cpha 0 the first bit must sit on miso before the first edge.
   task automatic prime();
      if (!cpha_i && (reply_q.size() > 0))
      begin
         tx_sr  = reply_q.pop_front();
         miso_o = tx_sr[7];
      end
   endtask

   always @(sclk_i)
   begin
      if (sclk_i == ~(cpol_i ^ cpha_i))
      begin
         rx_sr   = {rx_sr[6:0], mosi_i};   // sample edge.
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8)
         begin
            bit_cnt   = 0;
            last_rx_o = rx_sr;
            captured_q.push_back(rx_sr);
         end
      end
      else if (cpha_i)
      begin
         if ((bit_cnt == 0) && (reply_q.size() > 0))
            tx_sr = reply_q.pop_front();
         miso_o = tx_sr[7];
         tx_sr  = {tx_sr[6:0], 1'b0};
      end
      else
      begin
         if (bit_cnt == 0)
         begin
            if (reply_q.size() > 0)
               tx_sr = reply_q.pop_front();   // next byte of a burst.
         end
         else
            tx_sr = {tx_sr[6:0], 1'b0};
         miso_o = tx_sr[7];
      end
   end

endmodule

// File: verification/tb_spi_master.sv
`timescale 1ns/10ps

module tb_spi_master;

   import spi_pkg::*;

   localparam int TIMEOUT_CYCLES = 20000;

   logic      clk_i;
   logic      rst_i;
   logic      stb_i;
   logic      we_i;
   reg_addr_t adr_i;
   bus_word_t dat_i;
   bus_word_t dat_o;
   logic      int_o;
   logic      miso;
   logic      mosi;
   logic      sclk;
   logic      slave_cpol;
   logic      slave_cpha;
   spi_byte_t last_rx;
   logic [7:0] lfsr_q;
   int        cycle_cnt;

   spi_master_top #(
      .BAUD_WIDTH (8),
      .SPI_MODE   (4)
   ) UUT (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .stb_i  (stb_i),
      .we_i   (we_i),
      .adr_i  (adr_i),
      .dat_i  (dat_i),
      .dat_o  (dat_o),
      .int_o  (int_o),
      .miso_i (miso),
      .mosi_o (mosi),
      .sclk_o (sclk)
   );

   spi_slave_model slave (
      .sclk_i    (sclk),
      .mosi_i    (mosi),
      .cpol_i    (slave_cpol),
      .cpha_i    (slave_cpha),
      .miso_o    (miso),
      .last_rx_o (last_rx)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // failure reporting and checks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
      if (act !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
      if (act !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_with_failure($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
   endtask

   always @(posedge clk_i)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         stop_with_failure("the run hung, no transfer finished before the cycle limit");
   end

   // x^8 + x^6 + x^5 + x^4 + 1.
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic draw_byte(output spi_byte_t b);
      b = '0;
      for (int i = 0; i < 8; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         b      = {b[6:0], lfsr_q[0]};
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus access.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic bus_write(input reg_addr_t a, input bus_word_t d);
      @(negedge clk_i);
      stb_i = 1'b1;
      we_i  = 1'b1;
      adr_i = a;
      dat_i = d;
      @(negedge clk_i);
      stb_i = 1'b0;
      we_i  = 1'b0;
      dat_i = '0;
   endtask

   task automatic bus_read(input reg_addr_t a, output bus_word_t d);
      @(negedge clk_i);
      adr_i = a;
      stb_i = 1'b1;
      we_i  = 1'b0;
      #1;
      d = dat_o;
      @(negedge clk_i);
      stb_i = 1'b0;
   endtask

   task automatic wait_idle();
      bus_word_t w;
      w = '0;
      while (w[0] !== 1'b1)
         bus_read(ADDR_IRQ, w);
   endtask

   task automatic set_mode(input logic [1:0] m);
      bus_write(ADDR_MODE, {30'd0, m});
      slave_cpol = m[1];
      slave_cpha = m[0];
      repeat (2) @(negedge clk_i);
      slave.clear();   // drop edges from the idle level change.
   endtask

   task automatic run_byte(input spi_byte_t b, input spi_byte_t r, input string name);
      bus_word_t w;
      slave.push_reply(r);
      slave.prime();
      bus_write(ADDR_TXBUF, {24'd0, b});
      wait_idle();
      bus_read(ADDR_RXSHIFT, w);
      check_byte({name, " rx"}, r, w[7:0]);
      check_word({name, " count"}, 32'd1, 32'(slave.captured_q.size()));
      check_byte({name, " mosi"}, b, last_rx);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic test_reset();
      bus_word_t w;
      check_bit("reset int", 1'b0, int_o);
      check_bit("reset sclk", 1'b0, sclk);
      bus_read(ADDR_IRQ, w);
      check_word("reset status", 32'h3, w);
   endtask

   task automatic test_single_mode0();
      spi_byte_t b;
      spi_byte_t r;
      bus_write(ADDR_BAUD, 32'd1);
      set_mode(2'd0);
      draw_byte(b);
      draw_byte(r);
      run_byte(b, r, "single mode0");
   endtask

   task automatic test_all_modes();
      spi_byte_t b;
      spi_byte_t r;
      for (int m = 0; m < 4; m++)
      begin
         set_mode(2'(m));
         check_bit($sformatf("mode%0d idle sclk", m), slave_cpol, sclk);
         draw_byte(b);
         draw_byte(r);
         run_byte(b, r, $sformatf("mode%0d", m));
         check_bit($sformatf("mode%0d end sclk", m), slave_cpol, sclk);
      end
   endtask

   task automatic test_baud();
      int        divs[3];
      int        d;
      int        n;
      int        first;
      int        last;
      int        edges;
      logic      prev;
      spi_byte_t b;
      divs = '{0, 3, 7};
      set_mode(2'd1);   // first edge opens the byte.
      foreach (divs[i])
      begin
         d = divs[i];
         bus_write(ADDR_BAUD, 32'(d));
         slave.clear();
         slave.push_reply(8'h00);
         draw_byte(b);
         bus_write(ADDR_TXBUF, {24'd0, b});
         adr_i = ADDR_IRQ;
         prev  = sclk;
         n     = 0;
         first = -1;
         last  = 0;
         edges = 0;
         while (n < 16 * 8 + 40)
         begin
            @(negedge clk_i);
            n = n + 1;
            if (sclk !== prev)
            begin
               if (first < 0)
                  first = n;
               else
                  check_word($sformatf("baud %0d half", d), 32'(d + 1), 32'(n - last));
               last  = n;
               edges = edges + 1;
               prev  = sclk;
            end
            if ((first >= 0) && (dat_o[0] === 1'b1))
               break;
         end
         if (first < 0)
            stop_with_failure("no sclk edge appeared during the divisor test");
         check_word($sformatf("baud %0d edges", d), 32'd16, 32'(edges));
         check_word($sformatf("baud %0d span", d), 32'(16 * (d + 1)), 32'(n - first));
      end
   endtask

   task automatic test_back_to_back();
      spi_byte_t b1;
      spi_byte_t b2;
      spi_byte_t r1;
      spi_byte_t r2;
      bus_word_t w;
      bus_write(ADDR_BAUD, 32'd3);
      set_mode(2'd0);
      draw_byte(b1);
      draw_byte(b2);
      draw_byte(r1);
      draw_byte(r2);
      slave.push_reply(r1);
      slave.push_reply(r2);
      slave.prime();
      bus_write(ADDR_TXBUF, {24'd0, b1});
      bus_write(ADDR_TXBUF, {24'd0, b2});
      bus_read(ADDR_IRQ, w);
      check_bit("b2b queued ready", 1'b0, w[1]);
      while (w[1] !== 1'b1)
      begin
         check_bit("b2b busy", 1'b0, w[0]);
         bus_read(ADDR_IRQ, w);
      end
      wait_idle();
      bus_read(ADDR_TXBUF, w);
      check_byte("b2b first rx", r1, w[7:0]);
      bus_read(ADDR_RXSHIFT, w);
      check_byte("b2b second rx", r2, w[7:0]);
      check_word("b2b count", 32'd2, 32'(slave.captured_q.size()));
      check_byte("b2b mosi 0", b1, slave.captured_q[0]);
      check_byte("b2b mosi 1", b2, slave.captured_q[1]);
   endtask

   task automatic test_irq();
      spi_byte_t b;
      bus_word_t w;
      bus_write(ADDR_BAUD, 32'd1);
      set_mode(2'd0);
      bus_write(ADDR_IRQ, 32'h1);   // tx-empty only.
      slave.push_reply(8'h00);
      slave.prime();
      draw_byte(b);
      bus_write(ADDR_TXBUF, {24'd0, b});
      @(negedge clk_i);
      check_bit("irq empty busy", 1'b0, int_o);
      wait_idle();
      check_bit("irq empty done", 1'b1, int_o);
      bus_write(ADDR_IRQ, 32'h2);   // tx-ready only.
      slave.clear();
      slave.push_reply(8'h00);
      slave.push_reply(8'h00);
      slave.prime();
      draw_byte(b);
      bus_write(ADDR_TXBUF, {24'd0, b});
      draw_byte(b);
      bus_write(ADDR_TXBUF, {24'd0, b});
      check_bit("irq ready queued", 1'b0, int_o);
      w = '0;
      while (w[1] !== 1'b1)
         bus_read(ADDR_IRQ, w);
      check_bit("irq ready loaded", 1'b1, int_o);
      wait_idle();
      bus_write(ADDR_IRQ, 32'h0);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sequence.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin
      rst_i      = 1'b1;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = ADDR_RXSHIFT;
      dat_i      = '0;
      slave_cpol = 1'b0;
      slave_cpha = 1'b0;
      lfsr_q     = 8'd22;
      cycle_cnt  = 0;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      test_reset();
      test_single_mode0();
      test_all_modes();
      test_baud();
      test_back_to_back();
      test_irq();

      $display("STATUS: PASS");
      $finish;
   end

endmodule
